// ==== matrix_defs.svh ====
`ifndef MATRIX_DEFS_SVH
`define MATRIX_DEFS_SVH

// --------------------
// Bus widths
// --------------------
`define MATRIX_ADDR_W    32     // HADDR width
`define MATRIX_DATA_W    32     // HWDATA and HRDATA width

// --------------------
// Matrix size
// --------------------
// Fixed by the arbiter decode
`define MATRIX_NUM_PORTS 3      // Master ports

`endif

// ==== ahb_pkg.sv ====
`include "matrix_defs.svh"

package ahb_pkg;

    typedef logic [`MATRIX_ADDR_W-1:0] haddr_t;   // Byte address
    typedef logic [`MATRIX_DATA_W-1:0] hdata_t;   // Data bus word

    // Transfer type
    typedef logic [1:0] htrans_t;
    localparam htrans_t TRN_IDLE   = 2'b00;
    localparam htrans_t TRN_BUSY   = 2'b01;
    localparam htrans_t TRN_NONSEQ = 2'b10;       // First beat
    localparam htrans_t TRN_SEQ    = 2'b11;       // Later beats

    // Burst type
    typedef logic [2:0] hburst_t;
    localparam hburst_t BUR_SINGLE = 3'b000;
    localparam hburst_t BUR_INCR   = 3'b001;      // Undefined length
    localparam hburst_t BUR_WRAP4  = 3'b010;
    localparam hburst_t BUR_INCR4  = 3'b011;
    localparam hburst_t BUR_WRAP8  = 3'b100;
    localparam hburst_t BUR_INCR8  = 3'b101;
    localparam hburst_t BUR_WRAP16 = 3'b110;
    localparam hburst_t BUR_INCR16 = 3'b111;

    typedef logic [2:0] hsize_t;                  // Bytes as a power of two

    // Response
    typedef logic hresp_t;
    localparam hresp_t RESP_OKAY  = 1'b0;
    localparam hresp_t RESP_ERROR = 1'b1;

endpackage

// ==== matrix_pkg.sv ====
package matrix_pkg;

    // Master port number 0 to 2
    typedef logic [1:0] port_idx_t;

    // Beats left in a fixed-length burst
    typedef logic [3:0] burst_cnt_t;

    // Input stage FSM
    typedef enum logic {
        IN_PASS,    // Live transfer goes straight through
        IN_HELD     // Captured, waiting for grant
    } in_state_t;

endpackage

// ==== ahb_addr_if.sv ====
`timescale 1ns/1ps

interface ahb_addr_if
    import ahb_pkg::*;
();

    logic    req;           // Stage wants the slave
    haddr_t  haddr;
    htrans_t htrans;
    hburst_t hburst;
    logic    hwrite;
    hsize_t  hsize;
    logic    hmastlock;
    logic    active;        // Held or live transfer, the port's HSELM

    // Back from the output stage
    logic    grant;         // Port owns the slave address phase
    logic    hready;        // Slave HREADY

    modport source (
        output req, haddr, htrans, hburst, hwrite, hsize, hmastlock, active,
        input  grant, hready
    );

    modport sink (
        input  req, haddr, htrans, hburst, hwrite, hsize, hmastlock, active,
        output grant, hready
    );

endinterface

// ==== ahb_input_stage.sv ====
`timescale 1ns/1ps

module ahb_input_stage
    import ahb_pkg::*;
    import matrix_pkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,

    // Master address phase
    input  haddr_t     i_haddr,
    input  htrans_t    i_htrans,
    input  hburst_t    i_hburst,
    input  logic       i_hwrite,
    input  hsize_t     i_hsize,
    input  logic       i_hmastlock,
    input  logic       i_hready_in,     // Routed data-phase ready for this master

    output logic       o_hready_stall,  // Low while a transfer waits for grant

    ahb_addr_if.source addr
);

    in_state_t state_q;
    in_state_t state_d;

    // Captured address phase
    haddr_t    haddr_q;
    htrans_t   htrans_q;
    hburst_t   hburst_q;
    logic      hwrite_q;
    hsize_t    hsize_q;
    logic      hmastlock_q;

    logic      held;
    logic      live_xfer;   // Master presents NONSEQ or SEQ this cycle
    logic      accept;      // Slave takes our address phase now
    logic      capture;

    assign held      = (state_q == IN_HELD);
    assign live_xfer = i_hready_in && ((i_htrans == TRN_NONSEQ) || (i_htrans == TRN_SEQ));
    assign accept    = addr.grant && addr.hready;
    assign capture   = !held && live_xfer && !accept;  // No grant or slave stalled

    // --------------------
    // FSM
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IN_PASS: begin
                if (capture)
                    state_d = IN_HELD;
            end
            IN_HELD: begin
                if (accept)
                    state_d = IN_PASS;      // Held transfer issued
            end
            default: state_d = IN_PASS;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn)
            state_q <= IN_PASS;
        else
            state_q <= state_d;
    end

    // Payload only, valid while held
    always_ff @(posedge HCLK) begin
        if (capture) begin
            haddr_q     <= i_haddr;
            htrans_q    <= i_htrans;
            hburst_q    <= i_hburst;
            hwrite_q    <= i_hwrite;
            hsize_q     <= i_hsize;
            hmastlock_q <= i_hmastlock;
        end
    end

    // --------------------
    // Towards output stage
    // --------------------
    assign addr.haddr     = held ? haddr_q     : i_haddr;
    assign addr.htrans    = held ? htrans_q    : i_htrans;
    assign addr.hburst    = held ? hburst_q    : i_hburst;
    assign addr.hwrite    = held ? hwrite_q    : i_hwrite;
    assign addr.hsize     = held ? hsize_q     : i_hsize;
    assign addr.hmastlock = held ? hmastlock_q : i_hmastlock;

    assign addr.active = held || (i_htrans != TRN_IDLE);
    assign addr.req    = held || (i_htrans == TRN_NONSEQ);  // New transfer or held one

    // Master waits while held
    assign o_hready_stall = !held;

endmodule

// ==== ahb_output_arb.sv ====
`timescale 1ns/1ps

module ahb_output_arb
    import ahb_pkg::*;
    import matrix_pkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,

    input  logic [2:0] i_req,           // One per input stage
    input  logic       i_hready,        // Slave HREADY

    // Muxed address phase of the current owner
    input  logic       i_hsel,
    input  htrans_t    i_htrans,
    input  hburst_t    i_hburst,
    input  logic       i_hmastlock,

    output port_idx_t  o_addr_in_port,  // Owner of the address phase
    output logic       o_no_port        // Nobody wants the slave
);

    burst_cnt_t burst_cnt_q;
    burst_cnt_t burst_cnt_d;
    logic       burst_hold_q;           // Registered decode of a running burst
    logic       burst_hold_d;

    port_idx_t  port_q;
    port_idx_t  port_d;
    logic       no_port_q;
    logic       no_port_d;
    logic       owner_busy;             // Owner still has a real transfer

    // --------------------
    // Burst counter
    // --------------------
    always_comb begin
        burst_cnt_d  = burst_cnt_q;
        burst_hold_d = burst_hold_q;
        if (i_hready) begin
            if (!i_hsel) begin
                burst_cnt_d  = '0;      // Deselected mid-burst
                burst_hold_d = 1'b0;
            end else begin
                case (i_htrans)
                    TRN_NONSEQ: begin
                        burst_hold_d = 1'b1;
                        case (i_hburst)
                            BUR_WRAP16, BUR_INCR16: burst_cnt_d = 4'd15;
                            BUR_WRAP8, BUR_INCR8:   burst_cnt_d = 4'd7;
                            BUR_WRAP4, BUR_INCR4:   burst_cnt_d = 4'd3;
                            default: begin
                                burst_cnt_d  = '0;     // SINGLE or INCR
                                burst_hold_d = 1'b0;
                            end
                        endcase
                    end
                    TRN_SEQ: begin
                        if (burst_cnt_q != '0)
                            burst_cnt_d = burst_cnt_q - 1'b1;
                        if (burst_cnt_q == 4'd1)
                            burst_hold_d = 1'b0;       // Last beat
                    end
                    TRN_BUSY: burst_cnt_d = burst_cnt_q;   // Pause
                    default: begin
                        burst_cnt_d  = '0;     // IDLE ends it
                        burst_hold_d = 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            burst_cnt_q  <= '0;
            burst_hold_q <= 1'b0;
        end else begin
            burst_cnt_q  <= burst_cnt_d;
            burst_hold_q <= burst_hold_d;
        end
    end

    // --------------------
    // Port selection
    // --------------------
    // Port 0 wins, then 1, then 2
    assign owner_busy = i_hsel && (i_htrans != TRN_IDLE);

    always_comb begin
        port_d    = port_q;
        no_port_d = 1'b0;
        if (i_hmastlock || burst_hold_d) begin
            port_d = port_q;                        // Locked or mid-burst
        end else if (i_req[0] || (owner_busy && (port_q == 2'd0))) begin
            port_d = 2'd0;
        end else if (i_req[1] || (owner_busy && (port_q == 2'd1))) begin
            port_d = 2'd1;
        end else if (i_req[2] || (owner_busy && (port_q == 2'd2))) begin
            port_d = 2'd2;
        end else if (!i_hsel) begin
            no_port_d = 1'b1;
        end
        // Otherwise park on the selected owner
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            port_q    <= 2'd0;
            no_port_q <= 1'b1;
        end else if (i_hready) begin
            port_q    <= port_d;
            no_port_q <= no_port_d;
        end
    end

    assign o_addr_in_port = port_q;
    assign o_no_port      = no_port_q;

endmodule

// ==== ahb_output_stage.sv ====
`timescale 1ns/1ps
`include "matrix_defs.svh"

module ahb_output_stage
    import ahb_pkg::*;
    import matrix_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,

    ahb_addr_if.sink port0,
    ahb_addr_if.sink port1,
    ahb_addr_if.sink port2,

    // Master data phase
    output hdata_t   o_hrdata_m [`MATRIX_NUM_PORTS],
    output logic     o_hready_m [`MATRIX_NUM_PORTS],
    output hresp_t   o_hresp_m  [`MATRIX_NUM_PORTS],
    input  hdata_t   i_hwdata_m [`MATRIX_NUM_PORTS],

    // Shared slave
    output haddr_t   o_haddr,
    output htrans_t  o_htrans,
    output hburst_t  o_hburst,
    output logic     o_hwrite,
    output hsize_t   o_hsize,
    output logic     o_hmastlock,
    output logic     o_hsel,
    output hdata_t   o_hwdata,
    input  hdata_t   i_hrdata,
    input  logic     i_hreadyout,
    input  hresp_t   i_hresp
);

    localparam int NP = `MATRIX_NUM_PORTS;

    logic [NP-1:0] req;
    logic [NP-1:0] active;
    haddr_t        haddr_a  [NP];
    htrans_t       htrans_a [NP];
    hburst_t       hburst_a [NP];
    logic          hwrite_a [NP];
    hsize_t        hsize_a  [NP];
    logic          lock_a   [NP];

    port_idx_t     addr_port;   // Address phase owner
    logic          no_port;
    port_idx_t     data_port;   // Data phase owner
    logic          data_act;    // Data phase carries a real transfer

    // Gather the stages
    assign req      = {port2.req, port1.req, port0.req};
    assign active   = {port2.active, port1.active, port0.active};
    assign haddr_a  = '{port0.haddr, port1.haddr, port2.haddr};
    assign htrans_a = '{port0.htrans, port1.htrans, port2.htrans};
    assign hburst_a = '{port0.hburst, port1.hburst, port2.hburst};
    assign hwrite_a = '{port0.hwrite, port1.hwrite, port2.hwrite};
    assign hsize_a  = '{port0.hsize, port1.hsize, port2.hsize};
    assign lock_a   = '{port0.hmastlock, port1.hmastlock, port2.hmastlock};

    assign port0.grant  = !no_port && (addr_port == 2'd0);
    assign port1.grant  = !no_port && (addr_port == 2'd1);
    assign port2.grant  = !no_port && (addr_port == 2'd2);
    assign port0.hready = i_hreadyout;
    assign port1.hready = i_hreadyout;
    assign port2.hready = i_hreadyout;

    // --------------------
    // Address phase mux
    // --------------------
    assign o_haddr     = haddr_a[addr_port];
    assign o_hburst    = hburst_a[addr_port];
    assign o_hwrite    = hwrite_a[addr_port];
    assign o_hsize     = hsize_a[addr_port];
    assign o_hsel      = !no_port && active[addr_port];
    assign o_htrans    = no_port ? TRN_IDLE : htrans_a[addr_port];
    assign o_hmastlock = !no_port && lock_a[addr_port];

    ahb_output_arb ahb_output_arb_inst (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .i_req          (req),
        .i_hready       (i_hreadyout),
        .i_hsel         (o_hsel),
        .i_htrans       (o_htrans),
        .i_hburst       (o_hburst),
        .i_hmastlock    (o_hmastlock),
        .o_addr_in_port (addr_port),
        .o_no_port      (no_port)
    );

    // --------------------
    // Data phase routing
    // --------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            data_port <= 2'd0;
            data_act  <= 1'b0;
        end else if (i_hreadyout) begin
            data_port <= addr_port;
            data_act  <= o_hsel && o_htrans[1];     // NONSEQ or SEQ
        end
    end

    assign o_hwdata = i_hwdata_m[data_port];

    always_comb begin
        for (int n = 0; n < NP; n++) begin
            o_hrdata_m[n] = i_hrdata;
            o_hready_m[n] = 1'b1;       // No data phase here
            o_hresp_m[n]  = RESP_OKAY;
            if (data_act && (data_port == port_idx_t'(n))) begin
                o_hready_m[n] = i_hreadyout;
                o_hresp_m[n]  = i_hresp;
            end
        end
    end

endmodule

// ==== ahb_matrix_3x1.sv ====
`timescale 1ns/1ps
`include "matrix_defs.svh"

module ahb_matrix_3x1
    import ahb_pkg::*;
(
    input  logic    HCLK,
    input  logic    HRESETn,

    // Master 0
    input  haddr_t  i_haddr_m0,
    input  htrans_t i_htrans_m0,
    input  hburst_t i_hburst_m0,
    input  logic    i_hwrite_m0,
    input  hsize_t  i_hsize_m0,
    input  logic    i_hmastlock_m0,
    input  hdata_t  i_hwdata_m0,
    output hdata_t  o_hrdata_m0,
    output logic    o_hready_m0,
    output hresp_t  o_hresp_m0,

    // Master 1
    input  haddr_t  i_haddr_m1,
    input  htrans_t i_htrans_m1,
    input  hburst_t i_hburst_m1,
    input  logic    i_hwrite_m1,
    input  hsize_t  i_hsize_m1,
    input  logic    i_hmastlock_m1,
    input  hdata_t  i_hwdata_m1,
    output hdata_t  o_hrdata_m1,
    output logic    o_hready_m1,
    output hresp_t  o_hresp_m1,

    // Master 2
    input  haddr_t  i_haddr_m2,
    input  htrans_t i_htrans_m2,
    input  hburst_t i_hburst_m2,
    input  logic    i_hwrite_m2,
    input  hsize_t  i_hsize_m2,
    input  logic    i_hmastlock_m2,
    input  hdata_t  i_hwdata_m2,
    output hdata_t  o_hrdata_m2,
    output logic    o_hready_m2,
    output hresp_t  o_hresp_m2,

    // Slave
    output haddr_t  o_haddr,
    output htrans_t o_htrans,
    output hburst_t o_hburst,
    output logic    o_hwrite,
    output hsize_t  o_hsize,
    output logic    o_hmastlock,
    output logic    o_hsel,
    output hdata_t  o_hwdata,
    input  hdata_t  i_hrdata,
    input  logic    i_hreadyout,
    input  hresp_t  i_hresp
);

    hdata_t hrdata_m [`MATRIX_NUM_PORTS];
    logic   hready_m [`MATRIX_NUM_PORTS];   // Routed data-phase ready
    hresp_t hresp_m  [`MATRIX_NUM_PORTS];
    hdata_t hwdata_m [`MATRIX_NUM_PORTS];
    logic [`MATRIX_NUM_PORTS-1:0] stall_rdy;  // Low while a stage holds

    ahb_addr_if addr0_if ();
    ahb_addr_if addr1_if ();
    ahb_addr_if addr2_if ();

    ahb_input_stage ahb_input_stage_inst0 (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .i_haddr        (i_haddr_m0),
        .i_htrans       (i_htrans_m0),
        .i_hburst       (i_hburst_m0),
        .i_hwrite       (i_hwrite_m0),
        .i_hsize        (i_hsize_m0),
        .i_hmastlock    (i_hmastlock_m0),
        .i_hready_in    (hready_m[0]),
        .o_hready_stall (stall_rdy[0]),
        .addr           (addr0_if)
    );

    ahb_input_stage ahb_input_stage_inst1 (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .i_haddr        (i_haddr_m1),
        .i_htrans       (i_htrans_m1),
        .i_hburst       (i_hburst_m1),
        .i_hwrite       (i_hwrite_m1),
        .i_hsize        (i_hsize_m1),
        .i_hmastlock    (i_hmastlock_m1),
        .i_hready_in    (hready_m[1]),
        .o_hready_stall (stall_rdy[1]),
        .addr           (addr1_if)
    );

    ahb_input_stage ahb_input_stage_inst2 (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .i_haddr        (i_haddr_m2),
        .i_htrans       (i_htrans_m2),
        .i_hburst       (i_hburst_m2),
        .i_hwrite       (i_hwrite_m2),
        .i_hsize        (i_hsize_m2),
        .i_hmastlock    (i_hmastlock_m2),
        .i_hready_in    (hready_m[2]),
        .o_hready_stall (stall_rdy[2]),
        .addr           (addr2_if)
    );

    ahb_output_stage ahb_output_stage_inst (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .port0       (addr0_if),
        .port1       (addr1_if),
        .port2       (addr2_if),
        .o_hrdata_m  (hrdata_m),
        .o_hready_m  (hready_m),
        .o_hresp_m   (hresp_m),
        .i_hwdata_m  (hwdata_m),
        .o_haddr     (o_haddr),
        .o_htrans    (o_htrans),
        .o_hburst    (o_hburst),
        .o_hwrite    (o_hwrite),
        .o_hsize     (o_hsize),
        .o_hmastlock (o_hmastlock),
        .o_hsel      (o_hsel),
        .o_hwdata    (o_hwdata),
        .i_hrdata    (i_hrdata),
        .i_hreadyout (i_hreadyout),
        .i_hresp     (i_hresp)
    );

    assign hwdata_m = '{i_hwdata_m0, i_hwdata_m1, i_hwdata_m2};

    // Master HREADY is low on a held transfer or a waited data phase
    assign o_hready_m0 = hready_m[0] && stall_rdy[0];
    assign o_hready_m1 = hready_m[1] && stall_rdy[1];
    assign o_hready_m2 = hready_m[2] && stall_rdy[2];

    assign o_hrdata_m0 = hrdata_m[0];
    assign o_hrdata_m1 = hrdata_m[1];
    assign o_hrdata_m2 = hrdata_m[2];
    assign o_hresp_m0  = hresp_m[0];
    assign o_hresp_m1  = hresp_m[1];
    assign o_hresp_m2  = hresp_m[2];

endmodule

// ==== tb_ahb_matrix.sv ====
`timescale 1ns/1ps

module tb_ahb_matrix
    import ahb_pkg::*;
();

    localparam int NUM_ENTRIES = 17;

    typedef struct {
        logic [2:0]  mask;      // Active masters
        int          lead;      // Starts at once, the others after lag
        int          lag;       // Cycles
        hburst_t     burst;
        haddr_t      offset;    // Inside each master window
        logic        write;
        logic        lock;
        logic [15:0] seed;      // Write data pattern
        string       order;     // Port runs seen by the slave, empty skips
    } entry_t;

    entry_t  tbl [NUM_ENTRIES];
    logic    HCLK;
    logic    HRESETn;

    // Master side
    haddr_t  m_haddr  [3];
    htrans_t m_htrans [3];
    hburst_t m_hburst [3];
    logic    m_hwrite [3];
    hsize_t  m_hsize  [3];
    logic    m_hlock  [3];
    hdata_t  m_hwdata [3];
    hdata_t  m_hrdata [3];
    logic    m_hready [3];
    hresp_t  m_hresp  [3];

    // Slave side
    haddr_t  s_haddr;
    htrans_t s_htrans;
    hburst_t s_hburst;
    logic    s_hwrite;
    hsize_t  s_hsize;
    logic    s_hlock;
    logic    s_hsel;
    hdata_t  s_hwdata;
    hdata_t  s_hrdata;
    logic    s_hreadyout;
    hresp_t  s_hresp;

    // Slave model state
    logic    smp_sel, smp_write, smp_rdy, dph_valid, dph_write;
    htrans_t smp_trans;
    hburst_t smp_burst;
    hsize_t  smp_size;
    logic    smp_lock;
    haddr_t  smp_addr, dph_addr;
    hdata_t  smp_wdata;
    hdata_t  mem [haddr_t];
    hdata_t  exp_mem [haddr_t];     // Reference memory from the table
    haddr_t  slave_log [$];         // Accepted address phases
    int      cur_e = 0;             // Table entry on the bus
    integer  seed = 98023;

    ahb_matrix_3x1 ahb_matrix_3x1_inst (
        .HCLK (HCLK), .HRESETn (HRESETn),
        .i_haddr_m0 (m_haddr[0]), .i_htrans_m0 (m_htrans[0]), .i_hburst_m0 (m_hburst[0]),
        .i_hwrite_m0 (m_hwrite[0]), .i_hsize_m0 (m_hsize[0]), .i_hmastlock_m0 (m_hlock[0]),
        .i_hwdata_m0 (m_hwdata[0]), .o_hrdata_m0 (m_hrdata[0]), .o_hready_m0 (m_hready[0]),
        .o_hresp_m0 (m_hresp[0]),
        .i_haddr_m1 (m_haddr[1]), .i_htrans_m1 (m_htrans[1]), .i_hburst_m1 (m_hburst[1]),
        .i_hwrite_m1 (m_hwrite[1]), .i_hsize_m1 (m_hsize[1]), .i_hmastlock_m1 (m_hlock[1]),
        .i_hwdata_m1 (m_hwdata[1]), .o_hrdata_m1 (m_hrdata[1]), .o_hready_m1 (m_hready[1]),
        .o_hresp_m1 (m_hresp[1]),
        .i_haddr_m2 (m_haddr[2]), .i_htrans_m2 (m_htrans[2]), .i_hburst_m2 (m_hburst[2]),
        .i_hwrite_m2 (m_hwrite[2]), .i_hsize_m2 (m_hsize[2]), .i_hmastlock_m2 (m_hlock[2]),
        .i_hwdata_m2 (m_hwdata[2]), .o_hrdata_m2 (m_hrdata[2]), .o_hready_m2 (m_hready[2]),
        .o_hresp_m2 (m_hresp[2]),
        .o_haddr (s_haddr), .o_htrans (s_htrans), .o_hburst (s_hburst), .o_hwrite (s_hwrite),
        .o_hsize (s_hsize), .o_hmastlock (s_hlock), .o_hsel (s_hsel), .o_hwdata (s_hwdata),
        .i_hrdata (s_hrdata), .i_hreadyout (s_hreadyout), .i_hresp (s_hresp)
    );

    initial begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    initial begin
        #((NUM_ENTRIES * 200 + 10) * 10);
        $display("Simulation timed out before the stimulus table completed");
        $display("Test failures found");
        $fatal(1);
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic int burst_beats(hburst_t b);
        case (b)
            BUR_SINGLE:            return 1;
            BUR_INCR:              return 6;    // Undefined length, six here
            BUR_WRAP4, BUR_INCR4:  return 4;
            BUR_WRAP8, BUR_INCR8:  return 8;
            default:               return 16;
        endcase
    endfunction

    function automatic haddr_t beat_addr(int n, int e, int i);
        haddr_t start;
        haddr_t span;
        start = (haddr_t'(n) << 28) | tbl[e].offset;   // Port number in top bits
        span  = haddr_t'(burst_beats(tbl[e].burst) * 4);
        if (!tbl[e].burst[0] && (tbl[e].burst != BUR_SINGLE))
            return (start & ~(span - 1)) | ((start + 4 * i) & (span - 1));  // Wrap
        return start + 4 * i;
    endfunction

    function automatic hdata_t beat_data(int n, int e, int i);
        return {tbl[e].seed, 8'(n), 8'(i)};
    endfunction

    task automatic fail_run(string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // --------------------
    // Slave model
    // --------------------
    always @(negedge HCLK) begin
        smp_sel   = s_hsel;     // Values just before the next edge
        smp_trans = s_htrans;
        smp_addr  = s_haddr;
        smp_write = s_hwrite;
        smp_burst = s_hburst;
        smp_size  = s_hsize;
        smp_lock  = s_hlock;
        smp_wdata = s_hwdata;
        smp_rdy   = s_hreadyout;
    end

    always @(posedge HCLK) begin
        if (!HRESETn) begin
            dph_valid = 1'b0;
        end else if (smp_rdy) begin
            if (dph_valid && dph_write)
                mem[dph_addr] = smp_wdata;
            dph_valid = smp_sel && smp_trans[1];
            dph_addr  = smp_addr;
            dph_write = smp_write;
            if (dph_valid) begin
                slave_log.push_back(smp_addr);
                assert ((smp_burst == tbl[cur_e].burst) && (smp_size == 3'b010)
                        && (smp_lock == tbl[cur_e].lock))
                    else fail_run($sformatf("burst, size or lock wrong at slave %h", smp_addr));
            end
        end
        #1;
        s_hreadyout = dph_valid ? (($random(seed) & 3) != 0) : 1'b1;   // Random waits
        s_hrdata    = (dph_valid && mem.exists(dph_addr)) ? mem[dph_addr] : '0;
        s_hresp     = dph_valid ? RESP_OKAY : RESP_ERROR;   // Only meaningful in a data phase
    end

    // --------------------
    // Master driver
    // --------------------
    task automatic drive_master(int n, int e);
        int     beats;
        haddr_t a;
        beats = burst_beats(tbl[e].burst);
        if (n != tbl[e].lead)
            repeat (tbl[e].lag) begin
                @(posedge HCLK);
                #1;
            end
        for (int i = 0; i <= beats; i++) begin
            if (i < beats) begin
                m_haddr[n]  = beat_addr(n, e, i);
                m_htrans[n] = (i == 0) ? TRN_NONSEQ : TRN_SEQ;
                m_hburst[n] = tbl[e].burst;
                m_hwrite[n] = tbl[e].write;
                m_hlock[n]  = tbl[e].lock;
            end else begin
                m_htrans[n] = TRN_IDLE;
                m_hlock[n]  = 1'b0;
            end
            if ((i > 0) && tbl[e].write)
                m_hwdata[n] = beat_data(n, e, i - 1);   // Data phase of previous beat
            @(negedge HCLK);
            while (!m_hready[n])
                @(negedge HCLK);
            if (i > 0) begin
                a = beat_addr(n, e, i - 1);
                assert (m_hresp[n] == RESP_OKAY)
                    else fail_run($sformatf("master %0d error response at %h", n, a));
                if (!tbl[e].write)
                    assert (exp_mem.exists(a) && (m_hrdata[n] == exp_mem[a]))
                        else fail_run($sformatf("master %0d read %h got %h", n, a, m_hrdata[n]));
            end
            @(posedge HCLK);
            #1;
        end
    endtask

    // Slave log against the beats of the entry
    task automatic check_log(int e);
        haddr_t want [3][$];
        string  runs;
        int     last;
        int     p;
        runs = "";
        last = -1;
        for (int n = 0; n < 3; n++)
            if (tbl[e].mask[n])
                for (int i = 0; i < burst_beats(tbl[e].burst); i++)
                    want[n].push_back(beat_addr(n, e, i));
        foreach (slave_log[k]) begin
            p = int'(slave_log[k][29:28]);
            assert ((p < 3) && (want[p].size() > 0) && (slave_log[k] == want[p][0]))
                else fail_run($sformatf("unexpected slave address %h", slave_log[k]));
            void'(want[p].pop_front());
            if (p != last)
                runs = {runs, $sformatf("%0d", p)};     // New run of beats
            last = p;
        end
        for (int n = 0; n < 3; n++)
            assert (want[n].size() == 0)
                else fail_run($sformatf("entry %0d master %0d beats missing at slave", e, n));
        if (tbl[e].order != "")
            assert (runs == tbl[e].order)
                else fail_run($sformatf("entry %0d slave order %s, expected %s", e, runs,
                                        tbl[e].order));
        slave_log.delete();
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    initial begin
        tbl = '{
            '{3'b001, 0, 0, BUR_SINGLE, 32'h010, 1'b1, 1'b0, 16'h1a01, "0"},
            '{3'b010, 1, 0, BUR_SINGLE, 32'h010, 1'b1, 1'b0, 16'h1a02, "1"},
            '{3'b100, 2, 0, BUR_SINGLE, 32'h010, 1'b1, 1'b0, 16'h1a03, "2"},
            '{3'b001, 0, 0, BUR_SINGLE, 32'h010, 1'b0, 1'b0, 16'h0000, "0"},
            '{3'b010, 1, 0, BUR_SINGLE, 32'h010, 1'b0, 1'b0, 16'h0000, "1"},
            '{3'b100, 2, 0, BUR_SINGLE, 32'h010, 1'b0, 1'b0, 16'h0000, "2"},
            '{3'b111, 0, 0, BUR_SINGLE, 32'h040, 1'b1, 1'b0, 16'h2b00, "012"},
            '{3'b111, 0, 0, BUR_SINGLE, 32'h040, 1'b0, 1'b0, 16'h0000, "012"},
            '{3'b101, 2, 3, BUR_INCR8,  32'h100, 1'b1, 1'b0, 16'h3c00, "20"},
            '{3'b101, 2, 3, BUR_INCR8,  32'h100, 1'b0, 1'b0, 16'h0000, "20"},
            '{3'b011, 1, 3, BUR_WRAP4,  32'h208, 1'b1, 1'b0, 16'h4d00, "10"},
            '{3'b011, 1, 3, BUR_WRAP4,  32'h208, 1'b0, 1'b0, 16'h0000, "10"},
            '{3'b101, 2, 3, BUR_INCR16, 32'h300, 1'b1, 1'b0, 16'h5e00, "20"},
            '{3'b101, 2, 3, BUR_INCR16, 32'h300, 1'b0, 1'b0, 16'h0000, "20"},
            '{3'b011, 1, 3, BUR_INCR,   32'h400, 1'b1, 1'b1, 16'h6f00, "10"},
            '{3'b011, 1, 3, BUR_INCR,   32'h500, 1'b1, 1'b0, 16'h7000, "101"},
            '{3'b011, 1, 3, BUR_INCR,   32'h500, 1'b0, 1'b0, 16'h0000, "101"}
        };
        HRESETn     = 1'b0;
        s_hrdata    = '0;
        s_hreadyout = 1'b1;
        s_hresp     = RESP_OKAY;
        for (int n = 0; n < 3; n++) begin
            m_haddr[n]  = '0;
            m_htrans[n] = TRN_IDLE;
            m_hburst[n] = BUR_SINGLE;
            m_hwrite[n] = 1'b0;
            m_hsize[n]  = 3'b010;       // Word
            m_hlock[n]  = 1'b0;
            m_hwdata[n] = '0;
        end
        repeat (3) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        @(negedge HCLK);
        assert ((s_htrans == TRN_IDLE) && !s_hsel)
            else fail_run("slave not idle after reset");
        for (int n = 0; n < 3; n++)
            assert (m_hready[n] && (m_hresp[n] == RESP_OKAY))
                else fail_run($sformatf("master %0d not ready after reset", n));
        @(posedge HCLK);
        #1;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (tbl[e].write)
                for (int n = 0; n < 3; n++)
                    if (tbl[e].mask[n])
                        for (int i = 0; i < burst_beats(tbl[e].burst); i++)
                            exp_mem[beat_addr(n, e, i)] = beat_data(n, e, i);
            cur_e = e;
            fork
                if (tbl[e].mask[0]) drive_master(0, e);
                if (tbl[e].mask[1]) drive_master(1, e);
                if (tbl[e].mask[2]) drive_master(2, e);
            join
            repeat (3) @(posedge HCLK);     // Bus returns to no owner
            #1;
            check_log(e);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
ahb_pkg.sv
matrix_pkg.sv
ahb_addr_if.sv
ahb_input_stage.sv
ahb_output_arb.sv
ahb_output_stage.sv
ahb_matrix_3x1.sv
tb_ahb_matrix.sv

// ==== Bender.yml ====
package:
  name: ahb_matrix_3x1

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ahb_pkg.sv
      - matrix_pkg.sv
      - ahb_addr_if.sv
      - ahb_input_stage.sv
      - ahb_output_arb.sv
      - ahb_output_stage.sv
      - ahb_matrix_3x1.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ahb_matrix.sv
